/* common/dsp_pkg.sv */
// datapath widths, IQ and cos/sin field order and the quarter-wave sine table for the mixer
package dsp_pkg;

  // default widths, used as module parameter defaults through scoped names
  localparam int DEF_DATA_WIDTH  = 16;  // each of I and Q
  localparam int DEF_SC_WIDTH    = 16;  // each of cos and sin
  localparam int DEF_PHASE_WIDTH = 24;
  localparam int DEF_OUT_WIDTH   = 16;  // each of output I and Q

  // top phase bits that address the table, 64 steps per turn
  localparam int LUT_STEPS_LOG2 = 6;

  // field order used by every stream in the design
  //   IQ word     : I in the lower half, Q in the upper half
  //   cos/sin word: cos in the lower half, sin in the upper half

  localparam int QSIN_WIDTH = 16;  // table word width

  // 32767*sin(2*pi*k/64) for k = 0..16, first quadrant plus the end point
  localparam logic signed [QSIN_WIDTH-1:0] QSIN [17] = '{
    16'sd0,
    16'sd3212,
    16'sd6393,
    16'sd9512,
    16'sd12539,
    16'sd15446,
    16'sd18204,
    16'sd20787,
    16'sd23170,
    16'sd25329,
    16'sd27245,
    16'sd28898,
    16'sd30273,
    16'sd31356,
    16'sd32137,
    16'sd32609,
    16'sd32767
  };

endpackage

/* common/ctrl_pkg.sv */
// state type and idle limit of the phase flush controller, shared with the testbench
package ctrl_pkg;

  // flush controller states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // waiting for phase
    ST_RUN   = 2'd1,  // phase streaming
    ST_WAIT  = 2'd2,  // phase has stopped
    ST_FLUSH = 2'd3   // holding table valid until the IQ input is empty
  } tune_state_t;

  // idle accepted cycles in ST_WAIT that end a burst
  localparam int unsigned IDLE_LIMIT = 64;

endpackage

/* phase_ctrl/phase_flush_ctrl.sv */
// end-of-burst controller, holds table valid to drain queued IQ samples then clears the table
`timescale 1ns/1ps

module phase_flush_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic i_phase_valid,   // raw phase stream valid
  input  logic i_din_valid,     // IQ input still has samples queued
  input  logic i_lut_ready,     // table can take a phase
  input  logic i_eob,
  input  logic i_rate_changed,
  output logic o_phase_ready,   // ready seen by the phase source
  output logic o_hold_valid,    // forces table valid during flush
  output logic o_lut_clear      // two-cycle table clear
);

  import ctrl_pkg::*;

  tune_state_t state;
  logic [6:0]  idle_cnt;        // idle accepted cycles while waiting
  logic [1:0]  clear_sr;        // shifts out the clear pulse
  logic        burst_end;

  // no new phases while valid is forced
  assign o_phase_ready = i_lut_ready && !o_hold_valid;
  assign o_lut_clear   = clear_sr[0];

  // any of the three end conditions, judged only in ST_WAIT
  assign burst_end = i_eob || i_rate_changed || (idle_cnt >= IDLE_LIMIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      idle_cnt     <= '0;
      o_hold_valid <= 1'b0;
      clear_sr     <= 2'b00;
    end else begin
      clear_sr <= {1'b0, clear_sr[1]};  // pulse runs out on its own
      case (state)
        ST_IDLE: begin
          idle_cnt <= '0;
          if (i_phase_valid) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (!i_phase_valid) begin
            state <= ST_WAIT;              // phase gap, maybe end of burst
          end
        end
        ST_WAIT: begin
          if (i_lut_ready) begin
            idle_cnt <= idle_cnt + 7'd1;   // count only cycles the table could accept
          end
          if (i_phase_valid) begin
            state <= ST_IDLE;              // just a gap, keep going
          end else if (burst_end) begin
            state        <= ST_FLUSH;
            o_hold_valid <= 1'b1;
          end
        end
        ST_FLUSH: begin
          // table keeps producing until every queued IQ sample is paired
          if (!i_din_valid) begin
            state        <= ST_IDLE;
            o_hold_valid <= 1'b0;
            clear_sr     <= 2'b11;         // drop the extra table entries
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // forced valid must never outlive the flush
  a_no_hold_in_idle: assert property (
    @(posedge clk) disable iff (reset) (state == ST_IDLE) |-> !o_hold_valid
  ) else $error("hold_valid high in ST_IDLE");

endmodule

/* mixer/sin_cos_lut.sv */
// two-stage stallable quarter-wave table, turns a phase word into a {sin, cos} pair
`timescale 1ns/1ps

module sin_cos_lut #(
  parameter int PHASE_WIDTH = dsp_pkg::DEF_PHASE_WIDTH,
  parameter int SC_WIDTH    = dsp_pkg::DEF_SC_WIDTH
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_clear,        // empties both stages
  input  logic [PHASE_WIDTH-1:0] i_phase_data,
  input  logic                   i_phase_last,
  input  logic                   i_phase_valid,
  output logic                   o_phase_ready,
  output logic [2*SC_WIDTH-1:0]  o_sc_data,      // {sin, cos}
  output logic                   o_sc_last,
  output logic                   o_sc_valid,
  input  logic                   i_sc_ready
);

  import dsp_pkg::*;

  localparam int IDX_W = LUT_STEPS_LOG2 - 2;     // index within a quadrant

  logic [LUT_STEPS_LOG2-1:0]    phase_top;
  logic [1:0]                   s1_quad;
  logic [IDX_W-1:0]             s1_idx;
  logic                         s1_last;
  logic                         s1_valid;
  logic                         s1_ready;
  logic                         s2_ready;
  logic signed [QSIN_WIDTH-1:0] tab_fwd;         // sin of the index
  logic signed [QSIN_WIDTH-1:0] tab_rev;         // sin of the index plus 16 steps
  logic signed [QSIN_WIDTH-1:0] sin_w;
  logic signed [QSIN_WIDTH-1:0] cos_w;
  logic signed [SC_WIDTH-1:0]   sin_sc;
  logic signed [SC_WIDTH-1:0]   cos_sc;

  assign phase_top = i_phase_data[PHASE_WIDTH-1 -: LUT_STEPS_LOG2];

  // stage advances when empty or when its content moves on
  assign s2_ready      = !o_sc_valid || i_sc_ready;
  assign s1_ready      = !s1_valid || s2_ready;
  assign o_phase_ready = s1_ready && !i_clear;   // nothing accepted into a clear

  // quadrant symmetry, odd quadrants swap the table halves
  assign tab_fwd = QSIN[s1_idx];
  assign tab_rev = QSIN[(1 << IDX_W) - s1_idx];
  assign sin_w   = s1_quad[0] ? tab_rev : tab_fwd;
  assign cos_w   = s1_quad[0] ? tab_fwd : tab_rev;
  assign sin_sc  = SC_WIDTH'(s1_quad[1] ? -sin_w : sin_w) <<< (SC_WIDTH - QSIN_WIDTH);
  assign cos_sc  = SC_WIDTH'((s1_quad[1] ^ s1_quad[0]) ? -cos_w : cos_w)
                   <<< (SC_WIDTH - QSIN_WIDTH);

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      s1_valid   <= 1'b0;
      o_sc_valid <= 1'b0;
    end else begin
      if (s1_ready) s1_valid <= i_phase_valid;
      if (s2_ready) o_sc_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_quad <= phase_top[LUT_STEPS_LOG2-1 -: 2];
      s1_idx  <= phase_top[IDX_W-1:0];
      s1_last <= i_phase_last;
    end
    if (s2_ready) begin
      o_sc_data <= {sin_sc, cos_sc};
      o_sc_last <= s1_last;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk) disable iff (reset)
    o_sc_valid && !i_sc_ready && !i_clear |=> o_sc_valid && $stable(o_sc_data)
  ) else $error("cos/sin output changed while stalled");

endmodule

/* mixer/stream_sync.sv */
// one-entry join of the IQ and cos/sin streams, both inputs transfer on the same edge
`timescale 1ns/1ps

module stream_sync #(
  parameter int A_WIDTH = 2*dsp_pkg::DEF_DATA_WIDTH,  // IQ word
  parameter int B_WIDTH = 2*dsp_pkg::DEF_SC_WIDTH     // cos/sin word
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [A_WIDTH-1:0]         i_a_data,
  input  logic                       i_a_last,
  input  logic                       i_a_valid,
  output logic                       o_a_ready,
  input  logic [B_WIDTH-1:0]         i_b_data,
  input  logic                       i_b_valid,
  output logic                       o_b_ready,
  output logic [A_WIDTH+B_WIDTH-1:0] o_data,          // {b, a}
  output logic                       o_last,          // follows the IQ stream
  output logic                       o_valid,
  input  logic                       i_o_ready
);

  logic slot_free;
  logic take;

  assign slot_free = !o_valid || i_o_ready;
  assign take      = i_a_valid && i_b_valid && slot_free;  // pair moves together or not at all
  assign o_a_ready = i_b_valid && slot_free;
  assign o_b_ready = i_a_valid && slot_free;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
    end else if (slot_free) begin
      o_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_data <= {i_b_data, i_a_data};
      o_last <= i_a_last;
    end
  end

  // an accepted beat on either side lands in the output register with its partner
  a_joined: assert property (
    @(posedge clk) disable iff (reset)
    (i_a_valid && o_a_ready) || (i_b_valid && o_b_ready)
    |=> o_valid && (o_data == $past({i_b_data, i_a_data}))
  ) else $error("one stream accepted without the other");

endmodule

/* mixer/complex_mult.sv */
// two-stage stallable complex multiply of an IQ sample by a cos/sin pair, tlast carried along
`timescale 1ns/1ps

module complex_mult #(
  parameter int DATA_WIDTH = dsp_pkg::DEF_DATA_WIDTH,
  parameter int SC_WIDTH   = dsp_pkg::DEF_SC_WIDTH
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [2*DATA_WIDTH+2*SC_WIDTH-1:0]      i_data,       // {sin, cos, q, i}
  input  logic                                    i_last,
  input  logic                                    i_valid,
  output logic                                    o_ready,
  output logic [2*(DATA_WIDTH+SC_WIDTH+1)-1:0]    o_prod_data,  // {q, i} full width
  output logic                                    o_last,
  output logic                                    o_valid,
  input  logic                                    i_ready
);

  localparam int MW = DATA_WIDTH + SC_WIDTH;  // one product
  localparam int PW = MW + 1;                 // sum of two products

  logic signed [DATA_WIDTH-1:0] in_i, in_q;
  logic signed [SC_WIDTH-1:0]   in_cos, in_sin;
  logic signed [MW-1:0]         p_ic, p_qs, p_is, p_qc;
  logic signed [PW-1:0]         sum_i, sum_q;
  logic                         s1_valid, s1_last;
  logic                         s1_ready, s2_ready;

  assign in_i   = i_data[DATA_WIDTH-1:0];
  assign in_q   = i_data[2*DATA_WIDTH-1:DATA_WIDTH];
  assign in_cos = i_data[2*DATA_WIDTH+SC_WIDTH-1:2*DATA_WIDTH];
  assign in_sin = i_data[2*DATA_WIDTH+2*SC_WIDTH-1:2*DATA_WIDTH+SC_WIDTH];

  assign sum_i = p_ic - p_qs;  // i*cos - q*sin
  assign sum_q = p_is + p_qc;  // i*sin + q*cos

  assign s2_ready = !o_valid || i_ready;
  assign s1_ready = !s1_valid || s2_ready;
  assign o_ready  = s1_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      o_valid  <= 1'b0;
    end else begin
      if (s1_ready) s1_valid <= i_valid;
      if (s2_ready) o_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      p_ic    <= in_i * in_cos;
      p_qs    <= in_q * in_sin;
      p_is    <= in_i * in_sin;
      p_qc    <= in_q * in_cos;
      s1_last <= i_last;
    end
    if (s2_ready) begin
      o_prod_data <= {sum_q, sum_i};
      o_last      <= s1_last;
    end
  end

endmodule

/* rtl/round_complex.sv */
// one-stage round-half-up and saturate of both product halves down to the output width
`timescale 1ns/1ps

module round_complex #(
  parameter int IN_WIDTH  = dsp_pkg::DEF_DATA_WIDTH + dsp_pkg::DEF_SC_WIDTH + 1,
  parameter int OUT_WIDTH = dsp_pkg::DEF_OUT_WIDTH,
  parameter int SC_WIDTH  = dsp_pkg::DEF_SC_WIDTH    // sets the rounding point
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [2*IN_WIDTH-1:0]  i_data,   // {q, i}
  input  logic                   i_last,
  input  logic                   i_valid,
  output logic                   o_ready,
  output logic [2*OUT_WIDTH-1:0] o_data,   // {q, i}
  output logic                   o_last,
  output logic                   o_valid,
  input  logic                   i_ready
);

  localparam logic signed [IN_WIDTH:0] RND   = 1 <<< (SC_WIDTH - 2);  // half an output lsb
  localparam logic signed [IN_WIDTH:0] MAX_V = (1 <<< (OUT_WIDTH - 1)) - 1;
  localparam logic signed [IN_WIDTH:0] MIN_V = -(1 <<< (OUT_WIDTH - 1));

  function automatic logic [OUT_WIDTH-1:0] round_sat(input logic signed [IN_WIDTH-1:0] x);
    logic signed [IN_WIDTH:0] sum;
    logic signed [IN_WIDTH:0] shr;
    sum = x + RND;               // one extra bit so the add cannot wrap
    shr = sum >>> (SC_WIDTH - 1);
    if (shr > MAX_V) begin
      shr = MAX_V;
    end else if (shr < MIN_V) begin
      shr = MIN_V;
    end
    return shr[OUT_WIDTH-1:0];
  endfunction

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_ready) begin
      o_data <= {round_sat(i_data[2*IN_WIDTH-1:IN_WIDTH]), round_sat(i_data[IN_WIDTH-1:0])};
      o_last <= i_last;
    end
  end

endmodule

/* rtl/freq_tune_top.sv */
// frequency shifter top, rotates the IQ stream by the phase stream and rounds to output width
`timescale 1ns/1ps

module freq_tune_top #(
  parameter int DATA_WIDTH  = dsp_pkg::DEF_DATA_WIDTH,
  parameter int SC_WIDTH    = dsp_pkg::DEF_SC_WIDTH,
  parameter int PHASE_WIDTH = dsp_pkg::DEF_PHASE_WIDTH,
  parameter int OUT_WIDTH   = dsp_pkg::DEF_OUT_WIDTH
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_eob,           // end of burst strobe
  input  logic                     i_rate_changed,  // rate change strobe
  input  logic [2*DATA_WIDTH-1:0]  i_din_data,      // {q, i}
  input  logic                     i_din_last,
  input  logic                     i_din_valid,
  output logic                     o_din_ready,
  input  logic [PHASE_WIDTH-1:0]   i_phase_data,
  input  logic                     i_phase_last,
  input  logic                     i_phase_valid,
  output logic                     o_phase_ready,
  output logic [2*OUT_WIDTH-1:0]   o_dout_data,     // {q, i}
  output logic                     o_dout_last,
  output logic                     o_dout_valid,
  input  logic                     i_dout_ready
);

  localparam int SYNC_WIDTH = 2*DATA_WIDTH + 2*SC_WIDTH;  // {sin, cos, q, i}
  localparam int PROD_WIDTH = DATA_WIDTH + SC_WIDTH + 1;  // one full-width product half

  logic                    hold_valid;  // controller keeps the table fed
  logic                    lut_clear;
  logic                    lut_valid;
  logic                    lut_ready;
  logic [2*SC_WIDTH-1:0]   sc_data;     // {sin, cos}
  logic                    sc_valid;
  logic                    sc_ready;
  logic [SYNC_WIDTH-1:0]   sync_data;
  logic                    sync_last;
  logic                    sync_valid;
  logic                    sync_ready;
  logic [2*PROD_WIDTH-1:0] prod_data;   // {q, i} at full width
  logic                    prod_last;
  logic                    prod_valid;
  logic                    prod_ready;

  assign lut_valid = i_phase_valid || hold_valid;  // held valid drains in-flight samples

  phase_flush_ctrl u_ctrl (
    .clk(clk), .reset(reset),
    .i_phase_valid(i_phase_valid), .i_din_valid(i_din_valid), .i_lut_ready(lut_ready),
    .i_eob(i_eob), .i_rate_changed(i_rate_changed),
    .o_phase_ready(o_phase_ready), .o_hold_valid(hold_valid), .o_lut_clear(lut_clear)
  );

  sin_cos_lut #(.PHASE_WIDTH(PHASE_WIDTH), .SC_WIDTH(SC_WIDTH)) u_lut (
    .clk(clk), .reset(reset), .i_clear(lut_clear),
    .i_phase_data(i_phase_data), .i_phase_last(i_phase_last),
    .i_phase_valid(lut_valid), .o_phase_ready(lut_ready),
    .o_sc_data(sc_data), .o_sc_last(), .o_sc_valid(sc_valid), .i_sc_ready(sc_ready)
  );

  stream_sync #(.A_WIDTH(2*DATA_WIDTH), .B_WIDTH(2*SC_WIDTH)) u_sync (
    .clk(clk), .reset(reset),
    .i_a_data(i_din_data), .i_a_last(i_din_last), .i_a_valid(i_din_valid), .o_a_ready(o_din_ready),
    .i_b_data(sc_data), .i_b_valid(sc_valid), .o_b_ready(sc_ready),
    .o_data(sync_data), .o_last(sync_last), .o_valid(sync_valid), .i_o_ready(sync_ready)
  );

  complex_mult #(.DATA_WIDTH(DATA_WIDTH), .SC_WIDTH(SC_WIDTH)) u_mult (
    .clk(clk), .reset(reset),
    .i_data(sync_data), .i_last(sync_last), .i_valid(sync_valid), .o_ready(sync_ready),
    .o_prod_data(prod_data), .o_last(prod_last), .o_valid(prod_valid), .i_ready(prod_ready)
  );

  round_complex #(.IN_WIDTH(PROD_WIDTH), .OUT_WIDTH(OUT_WIDTH), .SC_WIDTH(SC_WIDTH)) u_round (
    .clk(clk), .reset(reset),
    .i_data(prod_data), .i_last(prod_last), .i_valid(prod_valid), .o_ready(prod_ready),
    .o_data(o_dout_data), .o_last(o_dout_last), .o_valid(o_dout_valid), .i_ready(i_dout_ready)
  );

endmodule

/* testbench/tb_checks.svh */
// LFSR, compare tasks and error counters, included inside the body of the testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int          iq_errors    = 0;         // wrong output samples
int          last_errors  = 0;         // wrong tlast
int          other_errors = 0;         // timeouts, stray outputs, protocol faults
logic [15:0] lfsr_state   = 16'd26384;

// galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) n = n ^ 16'hB400;
  return n;
endfunction

// one lfsr step per bit taken, first bit ends up as the msb
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  int          b;
  v = '0;
  for (b = 0; b < n; b++) begin
    lfsr_state = lfsr_step(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

task automatic check_iq(input logic [2*OUT_WIDTH-1:0] got, input logic [2*OUT_WIDTH-1:0] exp,
                        input string what);
  if (got !== exp) begin
    iq_errors++;
    $display("[FAIL] %0t %s: got i=%0d q=%0d, expected i=%0d q=%0d", $time, what,
             $signed(got[OUT_WIDTH-1:0]), $signed(got[2*OUT_WIDTH-1:OUT_WIDTH]),
             $signed(exp[OUT_WIDTH-1:0]), $signed(exp[2*OUT_WIDTH-1:OUT_WIDTH]));
  end
endtask

task automatic check_last(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    last_errors++;
    $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

/* testbench/tb_freq_tune.sv */
// testbench for the frequency shifter, directed tests checked against a sine table model
`timescale 1ns/1ps

module tb_freq_tune;

  import dsp_pkg::*;
  import ctrl_pkg::*;

  localparam int DATA_WIDTH  = DEF_DATA_WIDTH;
  localparam int SC_WIDTH    = DEF_SC_WIDTH;
  localparam int PHASE_WIDTH = DEF_PHASE_WIDTH;
  localparam int OUT_WIDTH   = DEF_OUT_WIDTH;
  localparam int STEPS       = 1 << LUT_STEPS_LOG2;  // table steps per turn
  localparam int WAIT_LIMIT  = 2000;                 // cycles any single wait may take
  localparam int EOB_WAIT    = 4;                    // eob to ST_FLUSH, far below the idle limit

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    i_eob;
  logic                    i_rate_changed;
  logic [2*DATA_WIDTH-1:0] i_din_data;
  logic                    i_din_last;
  logic                    i_din_valid;
  logic                    o_din_ready;
  logic [PHASE_WIDTH-1:0]  i_phase_data;
  logic                    i_phase_last;
  logic                    i_phase_valid;
  logic                    o_phase_ready;
  logic [2*OUT_WIDTH-1:0]  o_dout_data;
  logic                    o_dout_last;
  logic                    o_dout_valid;
  logic                    i_dout_ready;

  logic [PHASE_WIDTH-1:0]  phase_q[$];     // phases still to send
  logic [2*DATA_WIDTH-1:0] iq_q[$];        // IQ samples still to send
  logic                    iq_last_q[$];
  logic [2*OUT_WIDTH-1:0]  exp_data_q[$];  // model outputs in order
  logic                    exp_last_q[$];
  int                      checked = 0;

  `include "tb_checks.svh"

  freq_tune_top #(
    .DATA_WIDTH(DATA_WIDTH), .SC_WIDTH(SC_WIDTH),
    .PHASE_WIDTH(PHASE_WIDTH), .OUT_WIDTH(OUT_WIDTH)
  ) dut (
    .clk(clk), .reset(reset), .i_eob(i_eob), .i_rate_changed(i_rate_changed),
    .i_din_data(i_din_data), .i_din_last(i_din_last), .i_din_valid(i_din_valid),
    .o_din_ready(o_din_ready), .i_phase_data(i_phase_data), .i_phase_last(i_phase_last),
    .i_phase_valid(i_phase_valid), .o_phase_ready(o_phase_ready), .o_dout_data(o_dout_data),
    .o_dout_last(o_dout_last), .o_dout_valid(o_dout_valid), .i_dout_ready(i_dout_ready)
  );

  always #50 clk = ~clk;  // 100 ns period

  // full-turn sine of table step k from the quarter-wave table
  function automatic longint sine_of_step(input int k);
    int r;
    r = k % (STEPS / 4);
    case ((k / (STEPS / 4)) % 4)
      0:       return QSIN[r];
      1:       return QSIN[STEPS/4 - r];
      2:       return -QSIN[r];
      default: return -QSIN[STEPS/4 - r];
    endcase
  endfunction

  // round half up at the cos/sin binary point, then clip to the output range
  function automatic longint scale_to_out(input longint x);
    longint y;
    longint lim;
    lim = longint'(1) <<< (OUT_WIDTH - 1);
    y   = (x + (longint'(1) <<< (SC_WIDTH - 2))) >>> (SC_WIDTH - 1);
    if (y > lim - 1) y = lim - 1;
    if (y < -lim) y = -lim;
    return y;
  endfunction

  function automatic logic [2*OUT_WIDTH-1:0] predict(input logic [2*DATA_WIDTH-1:0] iq,
                                                   input logic [PHASE_WIDTH-1:0] phase);
    int     k;
    longint di;
    longint dq;
    longint c;
    longint s;
    longint ri;
    longint rq;
    k  = int'(phase >> (PHASE_WIDTH - LUT_STEPS_LOG2));  // only the top bits count
    di = longint'($signed(iq[DATA_WIDTH-1:0]));
    dq = longint'($signed(iq[2*DATA_WIDTH-1:DATA_WIDTH]));
    s  = sine_of_step(k) <<< (SC_WIDTH - QSIN_WIDTH);
    c  = sine_of_step((k + STEPS/4) % STEPS) <<< (SC_WIDTH - QSIN_WIDTH);  // quarter turn ahead
    ri = scale_to_out(di*c - dq*s);
    rq = scale_to_out(di*s + dq*c);
    return {rq[OUT_WIDTH-1:0], ri[OUT_WIDTH-1:0]};
  endfunction

  function automatic logic [2*DATA_WIDTH-1:0] make_iq(input int i, input int q);
    return {DATA_WIDTH'(q), DATA_WIDTH'(i)};
  endfunction

  function automatic logic [PHASE_WIDTH-1:0] step_phase(input int k);
    return PHASE_WIDTH'(k) << (PHASE_WIDTH - LUT_STEPS_LOG2);
  endfunction

  task automatic add_beat(input logic [2*DATA_WIDTH-1:0] iq, input logic [PHASE_WIDTH-1:0] ph,
                          input logic last);
    phase_q.push_back(ph);
    iq_q.push_back(iq);
    iq_last_q.push_back(last);
    exp_data_q.push_back(predict(iq, ph));
    exp_last_q.push_back(last);
  endtask

  // sample left for the flush, paired with whatever phase sits on the bus
  task automatic add_iq_without_phase(input logic [2*DATA_WIDTH-1:0] iq,
                                      input logic [PHASE_WIDTH-1:0] bus_phase, input logic last);
    iq_q.push_back(iq);
    iq_last_q.push_back(last);
    exp_data_q.push_back(predict(iq, bus_phase));
    exp_last_q.push_back(last);
  endtask

  task automatic add_random_burst(input int len);
    int j;
    for (j = 0; j < len; j++) begin
      add_beat(rand_bits(2*DATA_WIDTH), rand_bits(PHASE_WIDTH), j == len - 1);
    end
  endtask

  task automatic send_phases();
    int t;
    while (phase_q.size() > 0) begin
      i_phase_data  <= phase_q[0];
      i_phase_last  <= (phase_q.size() == 1);
      i_phase_valid <= 1'b1;
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!o_phase_ready && t < WAIT_LIMIT);
      if (!o_phase_ready) begin
        other_errors++;
        $display("timeout at %0t, phase stream never accepted a beat", $time);
        phase_q.delete();
      end else begin
        void'(phase_q.pop_front());
      end
    end
    i_phase_valid <= 1'b0;  // data stays on the bus
  endtask

  task automatic send_iq();
    int t;
    while (iq_q.size() > 0) begin
      i_din_data  <= iq_q[0];
      i_din_last  <= iq_last_q[0];
      i_din_valid <= 1'b1;
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!o_din_ready && t < WAIT_LIMIT);
      if (!o_din_ready) begin
        other_errors++;
        $display("timeout at %0t, IQ stream never accepted a sample", $time);
        iq_q.delete();
        iq_last_q.delete();
      end else begin
        void'(iq_q.pop_front());
        void'(iq_last_q.pop_front());
      end
    end
    i_din_valid <= 1'b0;
  endtask

  task automatic collect_outputs(input int n, input bit bp);
    int                     got;
    int                     t;
    logic                   stalled;
    logic [2*OUT_WIDTH-1:0] held;
    got     = 0;
    t       = 0;
    stalled = 1'b0;
    while (got < n && t < WAIT_LIMIT) begin
      @(posedge clk);
      t++;
      if (stalled && !o_dout_valid) begin
        other_errors++;
        $display("output valid dropped at %0t while waiting for ready", $time);
      end else if (stalled) begin
        check_iq(o_dout_data, held, "output changed while stalled");
      end
      if (o_dout_valid && i_dout_ready) begin
        check_iq(o_dout_data, exp_data_q.pop_front(), "output sample");
        check_last(o_dout_last, exp_last_q.pop_front(), "output tlast");
        got++;
        checked++;
        t = 0;
      end
      stalled = o_dout_valid && !i_dout_ready;
      held    = o_dout_data;
      i_dout_ready <= bp ? (rand_bits(1) != 0) : 1'b1;
    end
    if (got < n) begin
      other_errors++;
      $display("timeout at %0t, only %0d of %0d outputs arrived", $time, got, n);
      exp_data_q.delete();
      exp_last_q.delete();
    end
    i_dout_ready <= 1'b1;
  endtask

  // long enough for the idle flush to run, any output here is a duplicate
  task automatic settle();
    repeat (IDLE_LIMIT + 40) begin
      @(posedge clk);
      if (o_dout_valid) begin
        other_errors++;
        $display("unexpected output sample at %0t", $time);
      end
    end
  endtask

  task automatic run_stream(input bit bp);
    int n;
    n = exp_data_q.size();
    fork
      send_phases();
      send_iq();
      collect_outputs(n, bp);
    join
    settle();
  endtask

  task automatic end_burst_on_eob();
    int   t;
    logic flushed;
    t       = 0;
    flushed = 1'b0;
    while (phase_q.size() > 0 && t < WAIT_LIMIT) begin
      @(posedge clk);
      t++;
    end
    t = 0;
    while (dut.u_ctrl.state != ST_WAIT && t < WAIT_LIMIT) begin
      @(posedge clk);  // controller notices the phase gap
      t++;
    end
    if (dut.u_ctrl.state != ST_WAIT) begin
      other_errors++;
      $display("timeout at %0t, the controller never saw the phase gap", $time);
    end
    i_eob <= 1'b1;
    @(posedge clk);
    i_eob <= 1'b0;
    t = 0;
    while (!(flushed && dut.u_ctrl.state == ST_IDLE) && t < WAIT_LIMIT) begin
      @(posedge clk);
      t++;
      if (dut.u_ctrl.state == ST_FLUSH) begin
        flushed = 1'b1;
        if (o_phase_ready) begin
          other_errors++;
          $display("phase ready high at %0t during the flush", $time);
        end
      end else if (!flushed && t == EOB_WAIT) begin
        other_errors++;
        $display("no flush within %0d cycles of the eob pulse at %0t", EOB_WAIT, $time);
      end
    end
    if (t >= WAIT_LIMIT) begin
      other_errors++;
      $display("timeout at %0t, the flush never started or never ended", $time);
    end
  endtask

  task automatic test_zero_phase();
    add_beat(make_iq(0, 0), '0, 1'b0);
    add_beat(make_iq(1000, -2000), '0, 1'b0);
    add_beat(make_iq(32767, 32767), '0, 1'b0);    // full scale
    add_beat(make_iq(-32768, -32768), '0, 1'b0);
    add_beat(make_iq(32767, -32768), '0, 1'b0);
    add_beat(make_iq(-1, 1), '0, 1'b1);
    run_stream(1'b0);
  endtask

  task automatic test_quadrants();
    int k;
    for (k = 0; k < STEPS; k++) begin
      add_beat(make_iq(12000, -21000), step_phase(k), 1'b0);  // every step, odd ones too
    end
    for (k = STEPS/8; k < STEPS; k += STEPS/4) begin
      add_beat(make_iq(32767, 32767), step_phase(k), 1'b0);   // diagonals saturate a half
      add_beat(make_iq(-32768, -32768), step_phase(k), 1'b0);
    end
    add_beat(make_iq(-32768, 32767), step_phase(5), 1'b1);
    run_stream(1'b0);
  endtask

  task automatic test_random_bursts();
    int b;
    for (b = 0; b < 4; b++) begin
      add_random_burst(1 + rand_bits(3));
    end
    run_stream(1'b0);
  endtask

  task automatic test_back_pressure();
    int b;
    for (b = 0; b < 3; b++) begin
      add_random_burst(12);
    end
    run_stream(1'b1);
  endtask

  task automatic test_flush();
    int j;
    int n;
    for (j = 0; j < 4; j++) begin
      add_beat(rand_bits(2*DATA_WIDTH), '0, 1'b0);
    end
    for (j = 0; j < 3; j++) begin
      add_iq_without_phase(rand_bits(2*DATA_WIDTH), '0, j == 2);  // drained by held valid
    end
    n = exp_data_q.size();
    fork
      send_phases();
      send_iq();
      collect_outputs(n, 1'b0);
      end_burst_on_eob();
    join
    settle();
    add_random_burst(6);  // fresh burst after the table clear
    run_stream(1'b0);
  endtask

  initial begin
    reset          <= 1'b1;
    i_eob          <= 1'b0;
    i_rate_changed <= 1'b0;
    i_din_data     <= '0;
    i_din_last     <= 1'b0;
    i_din_valid    <= 1'b0;
    i_phase_data   <= '0;
    i_phase_last   <= 1'b0;
    i_phase_valid  <= 1'b0;
    i_dout_ready   <= 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    test_zero_phase();
    test_quadrants();
    test_random_bursts();
    test_back_pressure();
    test_flush();
    $display("outputs checked %0d, sample errors %0d, tlast errors %0d, other errors %0d",
             checked, iq_errors, last_errors, other_errors);
    if (iq_errors == 0 && last_errors == 0 && other_errors == 0 && checked > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+testbench
common/dsp_pkg.sv
common/ctrl_pkg.sv
phase_ctrl/phase_flush_ctrl.sv
mixer/sin_cos_lut.sv
mixer/stream_sync.sv
mixer/complex_mult.sv
rtl/round_complex.sv
rtl/freq_tune_top.sv
testbench/tb_freq_tune.sv

/* Bender.yml */
package:
  name: freq_tune

sources:
  - common/dsp_pkg.sv
  - common/ctrl_pkg.sv
  - phase_ctrl/phase_flush_ctrl.sv
  - mixer/sin_cos_lut.sv
  - mixer/stream_sync.sv
  - mixer/complex_mult.sv
  - rtl/round_complex.sv
  - rtl/freq_tune_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_freq_tune.sv
